//--- build.f
+incdir+rtl
rtl/epd_pkg.sv
rtl/epd_csr_apb.sv
rtl/epd_scan_timing.sv
rtl/epd_pixel_lane.sv
rtl/epd_source_out.sv
rtl/epd_controller.sv
tb/epd_tb.sv

//--- run.sh
#!/bin/sh
# Compile the EPD controller testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module epd_tb -o epd_sim \
    && ./obj_dir/epd_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/epd_tb.sv
/*
 * EPD controller testbench
 * Directed tests over the APB registers, scan timing, manual and
 * auto waveforms and underrun handling, with a framebuffer model
 */
`timescale 1ns/1ns
`include "epd_params.svh"

module epd_tb;

    // Small panel so a frame stays short
    localparam int HFP      = 2;
    localparam int HSYNC    = 2;
    localparam int HBP      = 1;
    localparam int HACT     = 4;
    localparam int VFP      = 1;
    localparam int VSYNC    = 2;
    localparam int VBP      = 1;
    localparam int VACT     = 3;
    localparam int WAVE_LEN = 5;
    localparam int HTOTAL   = HFP + HSYNC + HBP + HACT;
    localparam int VTOTAL   = VFP + VSYNC + VBP + VACT;
    localparam int WORDS    = VACT * HACT;

    localparam logic [31:0] HTIM_VAL = {8'(HACT), 8'(HBP), 8'(HSYNC), 8'(HFP)};
    localparam logic [31:0] VTIM_VAL = {8'(VACT), 8'(VBP), 8'(VSYNC), 8'(VFP)};

    // Run length bound from LUT loading and all frames of the tests
    localparam int FRAME_CYCLES = `EPD_VS_DELAY + 1 + HTOTAL * VTOTAL + 1;
    localparam int NUM_FRAMES   = 12;
    localparam int LUT_WRITES   = (WAVE_LEN + 1) * 256;
    localparam int MAX_CYCLES   = 2 * (LUT_WRITES * 4 + NUM_FRAMES * (2 * FRAME_CYCLES + 40))
                                  + 1000;

    logic                   clk;
    logic                   rst;
    logic [`EPD_APB_AW-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`EPD_APB_DW-1:0] pwdata;
    logic [`EPD_APB_DW-1:0] prdata;
    logic                   pready;
    logic                   sys_ready;
    logic [63:0]            bi_pixel = '0;
    logic                   bi_valid = 1'b0;
    logic                   bi_ready;
    logic [63:0]            bo_pixel;
    logic                   bo_valid;
    logic                   b_trigger;
    logic                   epd_gdsp;
    logic                   epd_gdclk;
    logic                   epd_sdle;
    logic [`EPD_SD_W-1:0]   epd_sd;
    logic                   epd_sdce0;

    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          frames_started = 0;
    int          words_out = 0;
    int          trig_run = 0;
    int          last_trig_len = 0;
    int          ready_cnt = 0;
    int          gdsp_low_cnt = 0;
    int          sdle_cnt = 0;
    int          run_pos = HTOTAL * VTOTAL + 1;
    logic        trig_prev = 1'b0;
    logic [5:0]  gf_model = '0;
    bit          pix_mode = 1'b0;
    int          drop_at = -1;
    int          word_idx = 0;
    bit          killed_model = 1'b0;
    logic [15:0] exp_sd_q[$];
    logic [63:0] exp_pix_q[$];

    epd_controller UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("ERROR: timeout after %0d cycles, %0d errors so far", cycle_cnt, errors);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Table contents used for every programmed entry
    function automatic logic [1:0] lut_pattern(input logic [13:0] a);
        logic [31:0] h;
        h = 32'(a) * 32'h9E37_79B1;
        return h[31:30];
    endfunction

    // Gate clock lags the column by one cycle, high from the sync region on
    function automatic logic gdclk_expect(input int pos);
        return pos >= 1 && pos <= HTOTAL * VTOTAL && (pos - 1) % HTOTAL >= HFP;
    endfunction

    function automatic logic [15:0] make_state(input bit auto_mode);
        logic [15:0] st;
        st = 16'($urandom);
        st[15] = auto_mode;
        if (!auto_mode)
            st[9:4] = 6'($urandom_range(WAVE_LEN, 0));
        return st;
    endfunction

    // Drive code in the top two bits, next state below
    function automatic logic [17:0] lane_expect(input logic [15:0] st, input logic [5:0] gf,
                                                input bit killed);
        logic [5:0]  cnt;
        logic [5:0]  seq;
        logic [3:0]  src;
        logic [1:0]  code;
        logic [1:0]  drv;
        logic [15:0] nxt;
        cnt  = st[15] ? gf : st[9:4];
        src  = st[15] ? st[7:4] : st[13:10];
        seq  = 6'(WAVE_LEN) - cnt;
        code = lut_pattern({seq, st[3:0], src});
        nxt  = st;
        drv  = 2'b00;
        if (!killed) begin
            if (st[15]) begin
                drv = code;
            end else if (cnt != 0) begin
                drv = code;
                nxt[9:4] = cnt - 6'd1;
            end else begin
                nxt[13:10] = st[3:0];
            end
        end
        return {drv, nxt};
    endfunction

    task automatic push_expected(input logic [63:0] word);
        logic [15:0] sd;
        logic [63:0] pix;
        logic [17:0] r;
        sd = '0;
        for (int i = 0; i < `EPD_LANES; i++) begin
            r = lane_expect(word[16*i +: 16], gf_model, killed_model);
            sd[2*i +: 2]    = r[17:16];
            pix[16*i +: 16] = r[15:0];
        end
        exp_sd_q.push_back(sd);
        exp_pix_q.push_back(pix);
    endtask

    // Framebuffer source answers every request in the same cycle
    always @(posedge clk) begin
        #1;
        if (b_trigger) begin
            word_idx = 0;
            killed_model = 1'b0;
        end
        if (bi_ready) begin
            if (word_idx == drop_at) begin
                bi_valid = 1'b0;
                killed_model = 1'b1;
            end else begin
                for (int i = 0; i < `EPD_LANES; i++)
                    bi_pixel[16*i +: 16] = make_state(pix_mode);
                bi_valid = 1'b1;
                push_expected(bi_pixel);
            end
            word_idx++;
        end else begin
            bi_valid = 1'b0;
        end
    end

    task automatic check_output;
        logic [15:0] sd;
        logic [63:0] pix;
        assert (exp_sd_q.size() != 0) else begin
            errors++;
            $display("ERROR: output word at %0t ns with no word outstanding", $time);
        end
        if (exp_sd_q.size() != 0) begin
            sd  = exp_sd_q.pop_front();
            pix = exp_pix_q.pop_front();
            words_out++;
            check_eq("epd_sd", epd_sd, sd);
            check_eq("bo_pixel", bo_pixel, pix);
            check_eq("epd_sdce0 on word", epd_sdce0, 1'b0);
        end
    endtask

    // Strobe counters restart with each frame, outputs checked every cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (b_trigger && !trig_prev) begin
                frames_started++;
                gf_model = (gf_model == 0) ? 6'(WAVE_LEN) : gf_model - 6'd1;
                trig_run = 0;
                ready_cnt = 0;
                gdsp_low_cnt = 0;
                sdle_cnt = 0;
            end
            if (b_trigger)
                trig_run++;
            if (!b_trigger && trig_prev) begin
                last_trig_len = trig_run;
                run_pos = 0;
            end
            if (bi_ready)
                ready_cnt++;
            if (!epd_gdsp)
                gdsp_low_cnt++;
            if (epd_sdle)
                sdle_cnt++;
            trig_prev = b_trigger;
            check_eq("epd_gdclk", epd_gdclk, gdclk_expect(run_pos));
            run_pos++;
            if (bo_valid) begin
                check_output();
            end else begin
                check_eq("idle epd_sd", epd_sd, 0);
                check_eq("idle epd_sdce0", epd_sdce0, 1'b1);
            end
        end
    end

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        check_eq("pready", pready, 1'b1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        apb_read(addr, rd);
        check_eq(what, rd, exp);
    endtask

    // Enable for n frames, then wait until the scan is idle and drained
    task automatic run_frames(input int n);
        int          target;
        logic [31:0] st;
        target = frames_started + n;
        apb_write(`EPD_REG_CTRL, 32'h1);
        wait (frames_started >= target);
        apb_write(`EPD_REG_CTRL, 32'h0);
        do
            apb_read(`EPD_REG_STATUS, st);
        while (st[0]);
        repeat (4) @(posedge clk);
    endtask

    task automatic load_lut;
        logic [13:0] addr;
        for (int seq = 0; seq <= WAVE_LEN; seq++)
            for (int tgt = 0; tgt < 16; tgt++)
                for (int src = 0; src < 16; src++) begin
                    addr = {6'(seq), 4'(tgt), 4'(src)};
                    apb_write(`EPD_REG_LUTWR, {14'd0, lut_pattern(addr), 2'd0, addr});
                end
    endtask

    task automatic test_registers;
        check_eq("b_trigger after reset", b_trigger, 1'b0);
        check_eq("bi_ready after reset", bi_ready, 1'b0);
        check_eq("epd_gdsp after reset", epd_gdsp, 1'b1);
        check_eq("epd_sdle after reset", epd_sdle, 1'b0);
        check_eq("epd_gdclk after reset", epd_gdclk, 1'b0);
        read_expect(`EPD_REG_CTRL, 32'h0, "CTRL reset");
        read_expect(`EPD_REG_HTIM, 32'h0, "HTIM reset");
        read_expect(`EPD_REG_VTIM, 32'h0, "VTIM reset");
        read_expect(`EPD_REG_LUTFR, 32'h0, "LUTFR reset");
        read_expect(`EPD_REG_STATUS, 32'h0, "STATUS reset");
        apb_write(`EPD_REG_HTIM, HTIM_VAL);
        apb_write(`EPD_REG_VTIM, VTIM_VAL);
        apb_write(`EPD_REG_LUTFR, 32'hFFFF_FFFF);
        read_expect(`EPD_REG_LUTFR, 32'h3F, "LUTFR width");
        apb_write(`EPD_REG_LUTFR, WAVE_LEN);
        // Timer stays idle while sys_ready is low
        apb_write(`EPD_REG_CTRL, 32'hFFFF_FFFF);
        read_expect(`EPD_REG_CTRL, 32'h1, "CTRL enable");
        read_expect(`EPD_REG_STATUS, 32'h0, "STATUS idle without sys_ready");
        apb_write(`EPD_REG_CTRL, 32'h0);
        read_expect(`EPD_REG_CTRL, 32'h0, "CTRL disable");
        apb_write(`EPD_REG_LUTWR, 32'h0003_0000);
        read_expect(`EPD_REG_LUTWR, 32'h0, "LUTWR read");
        read_expect(`EPD_REG_HTIM, HTIM_VAL, "HTIM readback");
        read_expect(`EPD_REG_VTIM, VTIM_VAL, "VTIM readback");
        read_expect(`EPD_REG_LUTFR, WAVE_LEN, "LUTFR readback");
    endtask

    task automatic test_frame_timing;
        logic [31:0] st0;
        logic [31:0] st1;
        @(posedge clk);
        #1;
        sys_ready = 1'b1;
        pix_mode = 1'b0;
        apb_read(`EPD_REG_STATUS, st0);
        run_frames(1);
        apb_read(`EPD_REG_STATUS, st1);
        check_eq("b_trigger cycles", last_trig_len, `EPD_VS_DELAY + 1);
        check_eq("bi_ready cycles", ready_cnt, WORDS);
        check_eq("epd_gdsp low cycles", gdsp_low_cnt, VSYNC * HTOTAL);
        check_eq("epd_sdle cycles", sdle_cnt, HSYNC * VTOTAL);
        check_eq("STATUS frame count", st1[15:8], 8'(st0[15:8] + 8'd1));
    endtask

    task automatic test_manual_waveform;
        int w0;
        pix_mode = 1'b0;
        w0 = words_out;
        run_frames(2);
        check_eq("manual words returned", words_out - w0, 2 * WORDS);
    endtask

    // Enough frames for the global sequence to wrap through a reload
    task automatic test_auto_waveform;
        int w0;
        pix_mode = 1'b1;
        w0 = words_out;
        run_frames(WAVE_LEN + 2);
        check_eq("auto words returned", words_out - w0, (WAVE_LEN + 2) * WORDS);
        pix_mode = 1'b0;
    endtask

    task automatic test_underrun_kill;
        logic [31:0] st;
        drop_at = 5;
        run_frames(1);
        apb_read(`EPD_REG_STATUS, st);
        check_eq("STATUS killed after underrun", st[1], 1'b1);
        drop_at = -1;
        run_frames(1);
        apb_read(`EPD_REG_STATUS, st);
        check_eq("STATUS killed after clean frame", st[1], 1'b0);
    endtask

    initial begin
        void'($urandom(29));
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        sys_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_registers();
        load_lut();
        test_frame_timing();
        test_manual_waveform();
        test_auto_waveform();
        test_underrun_kill();

        check_eq("words outstanding", exp_sd_q.size(), 0);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- rtl/epd_controller.sv
/*
 * EPD controller top level
 * Register block, scan timer, four pixel lanes and source output
 */
`timescale 1ns/1ns
`include "epd_params.svh"

module epd_controller (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`EPD_APB_AW-1:0]             paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [`EPD_APB_DW-1:0]             pwdata,
    output logic [`EPD_APB_DW-1:0]             prdata,
    output logic                               pready,
    input  logic                               sys_ready,
    input  logic [`EPD_LANES*`EPD_STATE_W-1:0] bi_pixel,
    input  logic                               bi_valid,
    output logic                               bi_ready,
    output logic [`EPD_LANES*`EPD_STATE_W-1:0] bo_pixel,
    output logic                               bo_valid,
    output logic                               b_trigger,
    output logic                               epd_gdsp,
    output logic                               epd_gdclk,
    output logic                               epd_sdle,
    output logic [`EPD_SD_W-1:0]               epd_sd,
    output logic                               epd_sdce0
);
    import epd_pkg::*;

    timing_cfg_t                  cfg;
    lut_wr_t                      lut_wr;
    scan_ctl_t                    ctl;
    lane_out_t [`EPD_LANES-1:0]   lane_res;
    logic                         scan_busy;
    logic                         frame_killed;
    logic [7:0]                   frame_count;

    epd_csr_apb u_csr (
        .clk          (clk),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .scan_busy    (scan_busy),
        .frame_killed (frame_killed),
        .frame_count  (frame_count),
        .prdata       (prdata),
        .pready       (pready),
        .cfg          (cfg),
        .lut_wr       (lut_wr)
    );

    epd_scan_timing u_timing (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .sys_ready    (sys_ready),
        .bi_valid     (bi_valid),
        .bi_ready     (bi_ready),
        .b_trigger    (b_trigger),
        .epd_gdsp     (epd_gdsp),
        .epd_gdclk    (epd_gdclk),
        .epd_sdle     (epd_sdle),
        .ctl          (ctl),
        .scan_busy    (scan_busy),
        .frame_killed (frame_killed),
        .frame_count  (frame_count)
    );

    // One lane per pixel of the framebuffer word, lane 0 lowest
    for (genvar i = 0; i < `EPD_LANES; i++) begin : g_lane
        epd_pixel_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .ctl      (ctl),
            .lut_wr   (lut_wr),
            .state_in (bi_pixel[i*`EPD_STATE_W +: `EPD_STATE_W]),
            .res      (lane_res[i])
        );
    end

    epd_source_out u_out (
        .clk       (clk),
        .rst       (rst),
        .res       (lane_res),
        .epd_sd    (epd_sd),
        .epd_sdce0 (epd_sdce0),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid)
    );

endmodule

//--- rtl/epd_source_out.sv
/*
 * EPD source output stage
 * Packs the lane drive codes onto the source bus and
 * returns the updated framebuffer word
 */
`timescale 1ns/1ns
`include "epd_params.svh"

module epd_source_out (
    input  logic                                     clk,
    input  logic                                     rst,
    input  epd_pkg::lane_out_t [`EPD_LANES-1:0]      res,
    output logic [`EPD_SD_W-1:0]                     epd_sd,
    output logic                                     epd_sdce0,
    output logic [`EPD_LANES*`EPD_STATE_W-1:0]       bo_pixel,
    output logic                                     bo_valid
);
    import epd_pkg::*;

    logic [2*`EPD_LANES-1:0] drive_q;
    logic                    valid_q;

    // All lanes see the same take and finish together
    // Bus reads zero between words
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            drive_q <= '0;
        end else begin
            valid_q <= res[0].valid;
            for (int i = 0; i < `EPD_LANES; i++)
                drive_q[2*i +: 2] <= res[0].valid ? res[i].drive : 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `EPD_LANES; i++)
            bo_pixel[i*`EPD_STATE_W +: `EPD_STATE_W] <= res[i].state;
    end

    assign epd_sd    = `EPD_SD_W'(drive_q);
    assign epd_sdce0 = !valid_q;
    assign bo_valid  = valid_q;

endmodule

//--- rtl/epd_pixel_lane.sv
/*
 * EPD pixel lane
 * Decodes one pixel state, looks up its drive code in a private
 * waveform table and computes the state written back
 */
`timescale 1ns/1ns
`include "epd_params.svh"

module epd_pixel_lane (
    input  logic                clk,
    input  logic                rst,
    input  epd_pkg::scan_ctl_t  ctl,
    input  epd_pkg::lut_wr_t    lut_wr,
    input  epd_pkg::pix_state_u state_in,
    output epd_pkg::lane_out_t  res
);
    import epd_pkg::*;

    // Address is sequence step, target level, source level
    logic [1:0] lut [0:(1 << `EPD_LUT_AW)-1];

    logic                   auto_mode;
    logic [`EPD_SEQ_W-1:0]  count;
    logic [`EPD_SEQ_W-1:0]  seq;
    logic [`EPD_GRAY_W-1:0] src;
    logic [`EPD_LUT_AW-1:0] rd_addr;
    logic                   drive_en;
    pix_state_u             next_state;

    logic                   valid_q;
    logic                   drive_en_q;
    logic [1:0]             rd_q;
    pix_state_u             state_q;

    always_comb begin
        auto_mode  = state_in.autolut.mode;
        count      = auto_mode ? ctl.gframe : state_in.manual.fcnt;
        src        = auto_mode ? state_in.autolut.src : state_in.manual.src;
        seq        = ctl.wave_len - count;
        rd_addr    = {seq, state_in.manual.tgt, src};
        drive_en   = ctl.frame_ok && (auto_mode || count != '0);
        next_state = state_in;
        // Manual pixels count down, then settle on the target level
        if (ctl.frame_ok && !auto_mode) begin
            if (count != '0)
                next_state.manual.fcnt = count - 1'b1;
            else
                next_state.manual.src = state_in.manual.tgt;
        end
    end

    always_ff @(posedge clk) begin
        if (lut_wr.we)
            lut[lut_wr.addr] <= lut_wr.data;
        rd_q <= lut[rd_addr];
    end

    always_ff @(posedge clk) begin
        drive_en_q <= drive_en;
        state_q    <= next_state;
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= ctl.take;
    end

    assign res = '{valid: valid_q, drive: drive_en_q ? rd_q : 2'b00, state: state_q};

endmodule

//--- rtl/epd_scan_timing.sv
/*
 * EPD scan timer
 * Idle, settle and scan states with line and column counters,
 * gate and source strobes, framebuffer requests and frame counters
 */
`timescale 1ns/1ns
`include "epd_params.svh"

module epd_scan_timing (
    input  logic                 clk,
    input  logic                 rst,
    input  epd_pkg::timing_cfg_t cfg,
    input  logic                 sys_ready,
    input  logic                 bi_valid,
    output logic                 bi_ready,
    output logic                 b_trigger,
    output logic                 epd_gdsp,
    output logic                 epd_gdclk,
    output logic                 epd_sdle,
    output epd_pkg::scan_ctl_t   ctl,
    output logic                 scan_busy,
    output logic                 frame_killed,
    output logic [7:0]           frame_count
);
    import epd_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RUN} scan_state_t;

    scan_state_t           state;
    logic [`EPD_CNT_W-1:0] h_cnt, v_cnt;
    logic [`EPD_CNT_W-1:0] h_sync_at, h_bp_at, h_act_at, htotal;
    logic [`EPD_CNT_W-1:0] v_sync_at, v_bp_at, v_act_at, vtotal;
    logic [`EPD_SEQ_W-1:0] gframe;
    logic                  frame_ok;
    logic                  gdclk_q;
    logic                  running, h_last, v_last;

    // Region boundaries, fp then sync then bp then active
    assign h_sync_at = `EPD_CNT_W'(cfg.hfp);
    assign h_bp_at   = h_sync_at + `EPD_CNT_W'(cfg.hsync);
    assign h_act_at  = h_bp_at + `EPD_CNT_W'(cfg.hbp);
    assign htotal    = h_act_at + `EPD_CNT_W'(cfg.hact);
    assign v_sync_at = `EPD_CNT_W'(cfg.vfp);
    assign v_bp_at   = v_sync_at + `EPD_CNT_W'(cfg.vsync);
    assign v_act_at  = v_bp_at + `EPD_CNT_W'(cfg.vbp);
    assign vtotal    = v_act_at + `EPD_CNT_W'(cfg.vact);

    assign running = (state == S_RUN);
    assign h_last  = (h_cnt == htotal - 1'b1);
    assign v_last  = (v_cnt == vtotal - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            h_cnt       <= '0;
            v_cnt       <= '0;
            gframe      <= '0;
            frame_ok    <= 1'b1;
            frame_count <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (cfg.enable && sys_ready)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    if (h_cnt == `EPD_CNT_W'(`EPD_VS_DELAY)) begin
                        state    <= S_RUN;
                        h_cnt    <= '0;
                        frame_ok <= 1'b1;
                        // Auto waveform sequence steps once per frame
                        gframe   <= (gframe == '0) ? cfg.wave_len : gframe - 1'b1;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                S_RUN: begin
                    if (h_last) begin
                        h_cnt <= '0;
                        if (v_last) begin
                            state       <= S_IDLE;
                            frame_count <= frame_count + 1'b1;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                    // Underrun masks the rest of the frame
                    if (bi_ready && !bi_valid)
                        frame_ok <= 1'b0;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Gate clock covers sync, bp and active columns, one cycle late
    always_ff @(posedge clk) begin
        if (rst)
            gdclk_q <= 1'b0;
        else
            gdclk_q <= running && (h_cnt >= h_sync_at);
    end

    assign epd_gdclk = gdclk_q;
    assign epd_gdsp  = !(running && v_cnt >= v_sync_at && v_cnt < v_bp_at);
    assign epd_sdle  = running && h_cnt >= h_sync_at && h_cnt < h_bp_at;
    assign bi_ready  = running && v_cnt >= v_act_at && h_cnt >= h_act_at;
    assign b_trigger = (state == S_WAIT);

    assign ctl = '{take: bi_ready && bi_valid, frame_ok: frame_ok,
                   gframe: gframe, wave_len: cfg.wave_len};

    assign scan_busy    = (state != S_IDLE);
    assign frame_killed = !frame_ok;

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        running |-> (h_cnt < htotal) && (v_cnt < vtotal));

endmodule

//--- rtl/epd_csr_apb.sv
/*
 * EPD register block
 * APB slave holding panel timing, enable and waveform length,
 * with a write port into the lane waveform tables
 */
`timescale 1ns/1ns
`include "epd_params.svh"

module epd_csr_apb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`EPD_APB_AW-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`EPD_APB_DW-1:0] pwdata,
    input  logic                   scan_busy,
    input  logic                   frame_killed,
    input  logic [7:0]             frame_count,
    output logic [`EPD_APB_DW-1:0] prdata,
    output logic                   pready,
    output epd_pkg::timing_cfg_t   cfg,
    output epd_pkg::lut_wr_t       lut_wr
);
    import epd_pkg::*;

    logic                   wr_en;
    logic                   lut_we_q;
    logic [`EPD_LUT_AW-1:0] lut_addr_q;
    logic [1:0]             lut_data_q;

    // No wait states
    assign pready = 1'b1;
    assign wr_en  = psel && penable && pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg      <= '0;
            lut_we_q <= 1'b0;
        end else begin
            lut_we_q <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    `EPD_REG_CTRL:  cfg.enable <= pwdata[0];
                    `EPD_REG_HTIM:  {cfg.hact, cfg.hbp, cfg.hsync, cfg.hfp} <= pwdata;
                    `EPD_REG_VTIM:  {cfg.vact, cfg.vbp, cfg.vsync, cfg.vfp} <= pwdata;
                    `EPD_REG_LUTFR: cfg.wave_len <= pwdata[`EPD_SEQ_W-1:0];
                    `EPD_REG_LUTWR: lut_we_q <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Table entry rides along with the one-cycle strobe
    always_ff @(posedge clk) begin
        if (wr_en && paddr == `EPD_REG_LUTWR) begin
            lut_addr_q <= pwdata[`EPD_LUT_AW-1:0];
            lut_data_q <= pwdata[17:16];
        end
    end

    assign lut_wr = '{we: lut_we_q, addr: lut_addr_q, data: lut_data_q};

    always_comb begin
        prdata = '0;
        case (paddr)
            `EPD_REG_CTRL:   prdata[0] = cfg.enable;
            `EPD_REG_HTIM:   prdata = {cfg.hact, cfg.hbp, cfg.hsync, cfg.hfp};
            `EPD_REG_VTIM:   prdata = {cfg.vact, cfg.vbp, cfg.vsync, cfg.vfp};
            `EPD_REG_LUTFR:  prdata[`EPD_SEQ_W-1:0] = cfg.wave_len;
            `EPD_REG_STATUS: prdata[15:0] = {frame_count, 6'd0, frame_killed, scan_busy};
            default:         prdata = '0;
        endcase
    end

    // Access phase is always preceded by a selected setup phase
    a_penable_sel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

//--- rtl/epd_pkg.sv
/*
 * EPD controller types
 * Configuration, LUT write and scan control bundles,
 * the two-view pixel state word and the lane result
 */
`include "epd_params.svh"

package epd_pkg;

    typedef struct packed {
        logic [7:0]            hfp;
        logic [7:0]            hsync;
        logic [7:0]            hbp;
        logic [7:0]            hact;
        logic [7:0]            vfp;
        logic [7:0]            vsync;
        logic [7:0]            vbp;
        logic [7:0]            vact;
        logic [`EPD_SEQ_W-1:0] wave_len;
        logic                  enable;
    } timing_cfg_t;

    typedef struct packed {
        logic                   we;
        logic [`EPD_LUT_AW-1:0] addr;
        logic [1:0]             data;
    } lut_wr_t;

    typedef struct packed {
        logic                  take;
        logic                  frame_ok;
        logic [`EPD_SEQ_W-1:0] gframe;
        logic [`EPD_SEQ_W-1:0] wave_len;
    } scan_ctl_t;

    // Manual mode keeps a per-pixel frame counter
    typedef struct packed {
        logic                   mode;
        logic                   spare;
        logic [`EPD_GRAY_W-1:0] src;
        logic [`EPD_SEQ_W-1:0]  fcnt;
        logic [`EPD_GRAY_W-1:0] tgt;
    } pix_manual_t;

    // Auto mode follows the global frame counter
    typedef struct packed {
        logic                   mode;
        logic [6:0]             spare;
        logic [`EPD_GRAY_W-1:0] src;
        logic [`EPD_GRAY_W-1:0] tgt;
    } pix_auto_t;

    typedef union packed {
        pix_manual_t manual;
        pix_auto_t   autolut;
    } pix_state_u;

    typedef struct packed {
        logic       valid;
        logic [1:0] drive;
        pix_state_u state;
    } lane_out_t;

endpackage

//--- rtl/epd_params.svh
/*
 * EPD controller parameters
 * Widths, lane count, settle delay and APB register offsets
 */
`ifndef EPD_PARAMS_SVH
`define EPD_PARAMS_SVH

// Datapath widths
`define EPD_LANES     4
`define EPD_STATE_W   16
`define EPD_CNT_W     11
`define EPD_SEQ_W     6
`define EPD_GRAY_W    4
`define EPD_LUT_AW    (`EPD_SEQ_W + 2 * `EPD_GRAY_W)
`define EPD_SD_W      16

// Cycles of settle after the trigger rises
`define EPD_VS_DELAY  8

// APB register map
`define EPD_APB_AW    8
`define EPD_APB_DW    32
`define EPD_REG_CTRL   8'h00
`define EPD_REG_HTIM   8'h04
`define EPD_REG_VTIM   8'h08
`define EPD_REG_LUTFR  8'h0C
`define EPD_REG_LUTWR  8'h10
`define EPD_REG_STATUS 8'h14

`endif
